/* logic/controlGen.sv */
module controlGen (
    input  decodePkg::decodedInstr_t held,
    input  logic heldValid,
    input  logic bubble,
    output decodePkg::controlSignals_t controls,
    output logic ctrlValid
);

    localparam decodePkg::regIdx_t linkReg = 5'd31; // $ra

    decodePkg::controlSignals_t expanded;
    decodePkg::dataWord_t extImm;

    always_comb
    begin
        case (held.immKind)
            decodePkg::immZero: extImm = {16'b0, held.imm16};
            decodePkg::immHigh: extImm = {held.imm16, 16'b0};
            decodePkg::immIndex: extImm = {6'b0, held.target};
            default: extImm = {{16{held.imm16[15]}}, held.imm16};
        endcase
    end

    always_comb
    begin
        expanded = decodePkg::controlNop;
        case (held.instrClass)
            decodePkg::clsAluReg, decodePkg::clsShiftVar:
            begin
                // variable shifts read the value through rt on port 1
                expanded.regRead1 = (held.instrClass == decodePkg::clsShiftVar) ? held.rt
                                                                              : held.rs;
                expanded.regRead2 = (held.instrClass == decodePkg::clsShiftVar) ? held.rs
                                                                              : held.rt;
                expanded.destinationRegister = held.rd;
                expanded.grfWriteSource = decodePkg::grfAlu;
            end
            decodePkg::clsShiftImm:
            begin
                expanded.regRead1 = held.rt;
                expanded.destinationRegister = held.rd;
                expanded.grfWriteSource = decodePkg::grfAlu;
                expanded.aluSrc = 1'b1;
                expanded.immediate = {27'b0, held.shamt};
            end
            decodePkg::clsAluImm, decodePkg::clsLui:
            begin
                expanded.regRead1 = held.rs;
                expanded.destinationRegister = held.rt;
                expanded.grfWriteSource = decodePkg::grfAlu;
                expanded.aluSrc = 1'b1;
                expanded.immediate = extImm;
            end
            decodePkg::clsLoad:
            begin
                expanded.regRead1 = held.rs;
                expanded.destinationRegister = held.rt;
                expanded.grfWriteSource = decodePkg::grfMem;
                expanded.aluSrc = 1'b1; // base plus offset
                expanded.immediate = extImm;
                expanded.memLoad = 1'b1;
            end
            decodePkg::clsStore:
            begin
                expanded.regRead1 = held.rs;
                expanded.regRead2 = held.rt;
                expanded.aluSrc = 1'b1;
                expanded.immediate = extImm;
                expanded.memStore = 1'b1;
            end
            decodePkg::clsBranchRs, decodePkg::clsBranchRsRt:
            begin
                expanded.regRead1 = held.rs;
                if (held.instrClass == decodePkg::clsBranchRsRt)
                    expanded.regRead2 = held.rt;
                expanded.branch = 1'b1;
                expanded.immediate = extImm;
            end
            decodePkg::clsJump:
            begin
                expanded.absJump = 1'b1;
                expanded.immediate = extImm;
            end
            decodePkg::clsJumpReg:
            begin
                expanded.regRead1 = held.rs;
                expanded.absJump = 1'b1;
                expanded.absJumpFromRegister = 1'b1;
            end
            default: expanded.regRead1 = '0; // exceptions and unknown
        endcase
        if (held.link)
        begin
            expanded.grfWriteSource = decodePkg::grfPc;
            expanded.destinationRegister = (held.instrClass == decodePkg::clsJumpReg) ? held.rd
                                                                                     : linkReg;
        end
        expanded.aluCtrl = held.aluOp;
        expanded.checkOverflow = held.checkOverflow;
        expanded.memWidthCtrl = held.memWidth;
        expanded.memReadSignExtend = held.signExtend;
        expanded.cmpCtrl = held.cmpOp;
        expanded.branchLikely = held.likely;
        expanded.exception = held.exception;
        expanded.unknownInstruction = held.unknown;
    end

    assign controls = bubble ? decodePkg::controlNop : expanded; // kill this cycle
    assign ctrlValid = heldValid;

endmodule

/* logic/decodeLatch.sv */
module decodeLatch (
    input  logic clk,
    input  logic rstN,
    input  logic instrValid,
    input  decodePkg::decodedInstr_t decoded,
    output decodePkg::decodedInstr_t held,
    output logic heldValid
);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            held <= '0;
            heldValid <= 1'b0;
        end
        else
        begin
            heldValid <= instrValid;
            if (instrValid)
            begin
                held <= decoded;
            end
            else
            begin
                held <= '0; // empty slot reads as nop
            end
        end
    end

endmodule

/* logic/decodePkg.sv */
package decodePkg;

    typedef logic [31:0] instrWord_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jumpTarget_t;
    typedef logic [31:0] dataWord_t;

    // format class picks the datapath shape
    typedef enum logic [3:0] {
        clsNone,
        clsAluReg,
        clsShiftImm,
        clsShiftVar,
        clsAluImm,
        clsLui,
        clsLoad,
        clsStore,
        clsBranchRs,      // compare rs against zero
        clsBranchRsRt,
        clsJump,
        clsJumpReg
    } instrClass_e;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNor,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu
    } aluOp_e;

    typedef enum logic [2:0] {
        cmpNone,
        cmpEq,
        cmpNe,
        cmpLez,
        cmpGtz,
        cmpLtz,
        cmpGez
    } cmpOp_e;

    typedef enum logic [1:0] {
        memNone,
        memByte,
        memHalf,
        memWord
    } memWidth_e;

    typedef enum logic [1:0] {
        immSign,
        immZero,
        immHigh,          // lui
        immIndex          // j, jal
    } immKind_e;

    typedef enum logic [1:0] {
        excNone,
        excSyscall,
        excBreak,
        excEret
    } exception_e;

    typedef enum logic [1:0] {
        grfNone,
        grfAlu,
        grfMem,
        grfPc
    } grfSource_e;

    typedef struct packed {
        instrClass_e instrClass;
        aluOp_e aluOp;
        cmpOp_e cmpOp;
        memWidth_e memWidth;
        logic signExtend;
        logic checkOverflow;
        immKind_e immKind;
        logic link;
        logic likely;
        exception_e exception;
        logic unknown;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t rd;
        logic [4:0] shamt;
        imm16_t imm16;
        jumpTarget_t target;
    } decodedInstr_t;

    typedef struct packed {
        regIdx_t regRead1;
        regIdx_t regRead2;
        regIdx_t destinationRegister;
        grfSource_e grfWriteSource;
        aluOp_e aluCtrl;
        logic aluSrc;             // 1 selects immediate as operand b
        dataWord_t immediate;
        logic checkOverflow;
        logic memLoad;
        logic memStore;
        memWidth_e memWidthCtrl;
        logic memReadSignExtend;
        logic branch;
        cmpOp_e cmpCtrl;
        logic branchLikely;
        logic absJump;
        logic absJumpFromRegister;
        exception_e exception;
        logic unknownInstruction;
    } controlSignals_t;

    localparam controlSignals_t controlNop = '0;

endpackage

/* logic/decodeTop.sv */
module decodeTop #(
    parameter bit implementLikely = 1'b1
) (
    input  logic clk,
    input  logic rstN,
    input  logic instrValid,
    input  decodePkg::instrWord_t instruction,
    input  logic bubble,
    output logic ctrlValid,
    output decodePkg::controlSignals_t controls
);

    decodePkg::decodedInstr_t decoded;
    decodePkg::decodedInstr_t held;
    logic heldValid;

    instrClassify #(
        .implementLikely(implementLikely)
    ) u_classify (
        .instruction(instruction),
        .decoded(decoded)
    );

    decodeLatch u_latch (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .decoded(decoded),
        .held(held),
        .heldValid(heldValid)
    );

    controlGen u_ctrl (
        .held(held),
        .heldValid(heldValid),
        .bubble(bubble),
        .controls(controls),
        .ctrlValid(ctrlValid)
    );

endmodule

/* logic/instrClassify.sv */
module instrClassify #(
    parameter bit implementLikely = 1'b1
) (
    input  decodePkg::instrWord_t instruction,
    output decodePkg::decodedInstr_t decoded
);

    logic [5:0] opcode;
    logic [5:0] funct;
    decodePkg::regIdx_t rs;
    decodePkg::regIdx_t rt;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];
    assign rs = instruction[25:21];
    assign rt = instruction[20:16];

    // low opcode bits give the access size
    function automatic decodePkg::memWidth_e memWidthOf(input logic [1:0] size);
        case (size)
            2'b00: return decodePkg::memByte;
            2'b01: return decodePkg::memHalf;
            default: return decodePkg::memWord;
        endcase
    endfunction

    always_comb
    begin
        decoded = '0;
        case (opcode)
            6'b000000: // SPECIAL
            begin
                case (funct)
                    6'b100000, 6'b100001, 6'b100010, 6'b100011, 6'b100100,
                    6'b100101, 6'b100110, 6'b100111, 6'b101010, 6'b101011:
                        decoded.instrClass = decodePkg::clsAluReg;
                    6'b000000, 6'b000010, 6'b000011:
                        decoded.instrClass = decodePkg::clsShiftImm;
                    6'b000100, 6'b000110, 6'b000111:
                        decoded.instrClass = decodePkg::clsShiftVar;
                    6'b001000: // jr
                        decoded.instrClass = decodePkg::clsJumpReg;
                    6'b001001: // jalr
                    begin
                        decoded.instrClass = decodePkg::clsJumpReg;
                        decoded.link = 1'b1;
                    end
                    6'b001100: decoded.exception = decodePkg::excSyscall;
                    6'b001101: decoded.exception = decodePkg::excBreak;
                    default: decoded.unknown = 1'b1; // mult/div, hi/lo, traps
                endcase
                case (funct)
                    6'b100010, 6'b100011: decoded.aluOp = decodePkg::aluSub;
                    6'b100100: decoded.aluOp = decodePkg::aluAnd;
                    6'b100101: decoded.aluOp = decodePkg::aluOr;
                    6'b100111: decoded.aluOp = decodePkg::aluNor;
                    6'b100110: decoded.aluOp = decodePkg::aluXor;
                    6'b101010: decoded.aluOp = decodePkg::aluSlt;
                    6'b101011: decoded.aluOp = decodePkg::aluSltu;
                    6'b000000, 6'b000100: decoded.aluOp = decodePkg::aluSll;
                    6'b000010, 6'b000110: decoded.aluOp = decodePkg::aluSrl;
                    6'b000011, 6'b000111: decoded.aluOp = decodePkg::aluSra;
                    default: decoded.aluOp = decodePkg::aluAdd; // add, addu
                endcase
                decoded.checkOverflow = (funct == 6'b100000) || (funct == 6'b100010);
            end
            6'b000001: // REGIMM where rt selects the branch
            begin
                decoded.instrClass = decodePkg::clsBranchRs;
                decoded.cmpOp = rt[0] ? decodePkg::cmpGez : decodePkg::cmpLtz;
                decoded.likely = rt[1];
                decoded.link = rt[4]; // bltzal, bgezal
                decoded.unknown = (rt[3:2] != 2'b00); // traps land here
            end
            6'b001000, 6'b001001, 6'b001010, 6'b001011,
            6'b001100, 6'b001101, 6'b001110, 6'b001111:
            begin
                decoded.instrClass = (opcode[2:0] == 3'b111) ? decodePkg::clsLui
                                                              : decodePkg::clsAluImm;
                case (opcode[2:0])
                    3'b010: decoded.aluOp = decodePkg::aluSlt;
                    3'b011: decoded.aluOp = decodePkg::aluSltu;
                    3'b100: decoded.aluOp = decodePkg::aluAnd;
                    3'b101: decoded.aluOp = decodePkg::aluOr;
                    3'b110: decoded.aluOp = decodePkg::aluXor;
                    default: decoded.aluOp = decodePkg::aluAdd; // addi, addiu, lui
                endcase
                if (opcode[2:0] == 3'b111)
                    decoded.immKind = decodePkg::immHigh;
                else if (opcode[2])
                    decoded.immKind = decodePkg::immZero; // logical ops
                decoded.checkOverflow = (opcode[2:0] == 3'b000); // addi
            end
            6'b100000, 6'b100001, 6'b100011, 6'b100100, 6'b100101: // loads
            begin
                decoded.instrClass = decodePkg::clsLoad;
                decoded.memWidth = memWidthOf(opcode[1:0]);
                decoded.signExtend = !opcode[2] && (opcode[1:0] != 2'b11); // lb, lh
            end
            6'b101000, 6'b101001, 6'b101011: // sb, sh, sw
            begin
                decoded.instrClass = decodePkg::clsStore;
                decoded.memWidth = memWidthOf(opcode[1:0]);
            end
            6'b000100, 6'b000101, 6'b010100, 6'b010101: // beq, bne and likely
            begin
                decoded.instrClass = decodePkg::clsBranchRsRt;
                decoded.cmpOp = opcode[0] ? decodePkg::cmpNe : decodePkg::cmpEq;
                decoded.likely = opcode[4];
            end
            6'b000110, 6'b000111, 6'b010110, 6'b010111: // blez, bgtz and likely
            begin
                decoded.instrClass = decodePkg::clsBranchRs;
                decoded.cmpOp = opcode[0] ? decodePkg::cmpGtz : decodePkg::cmpLez;
                decoded.likely = opcode[4];
            end
            6'b000010, 6'b000011: // j, jal
            begin
                decoded.instrClass = decodePkg::clsJump;
                decoded.immKind = decodePkg::immIndex;
                decoded.link = opcode[0];
            end
            6'b010000: // cop0 keeps only eret
            begin
                if (rs == 5'b10000 && funct == 6'b011000)
                    decoded.exception = decodePkg::excEret;
                else
                    decoded.unknown = 1'b1;
            end
            default: decoded.unknown = 1'b1;
        endcase
        if (!implementLikely && decoded.likely)
            decoded.unknown = 1'b1;
        // unknown carries no partial decode
        if (decoded.unknown)
        begin
            decoded = '0;
            decoded.unknown = 1'b1;
        end
        decoded.rs = rs;
        decoded.rt = rt;
        decoded.rd = instruction[15:11];
        decoded.shamt = instruction[10:6];
        decoded.imm16 = instruction[15:0];
        decoded.target = instruction[25:0];
    end

endmodule

/* project.f */
logic/decodePkg.sv
logic/instrClassify.sv
logic/decodeLatch.sv
logic/controlGen.sv
logic/decodeTop.sv
test/decodeTop_checker.sv
test/decodeTb.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module decodeTb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VdecodeTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

/* test/decodeTb.sv */
module decodeTb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk = 1'b0;
    logic rstN;
    logic instrValid;
    decodePkg::instrWord_t instruction;
    logic bubble;
    logic ctrlValid;
    decodePkg::controlSignals_t controls;

    logic [31:0] lfsrState = 32'h8e80_a111;
    decodePkg::regIdx_t rsR;
    decodePkg::regIdx_t rtR;
    decodePkg::regIdx_t rdR;
    logic [4:0] shR;
    decodePkg::imm16_t immR;

    decodeTop #(
        .implementLikely(1'b1)
    ) u_dut (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instruction(instruction),
        .bubble(bubble),
        .ctrlValid(ctrlValid),
        .controls(controls)
    );

    bind decodeTop decodeTop_checker u_checker (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .bubble(bubble),
        .ctrlValid(ctrlValid),
        .controls(controls)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic pickOperands;
        logic [31:0] v;
        takeBits(5, v);
        rsR = v[4:0];
        takeBits(5, v);
        rtR = v[4:0];
        takeBits(5, v);
        rdR = v[4:0];
        takeBits(5, v);
        shR = v[4:0];
        takeBits(16, v);
        immR = v[15:0];
    endtask

    function automatic decodePkg::instrWord_t rType(input logic [4:0] rs, rt, rd, sh,
                                                    input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic decodePkg::instrWord_t iType(input logic [5:0] op,
                                                    input logic [4:0] rs, rt,
                                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic decodePkg::dataWord_t signExt16(input decodePkg::imm16_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic decodePkg::controlSignals_t aluRegExpect(
        input decodePkg::regIdx_t ra, rb, rd, input decodePkg::aluOp_e op, input logic ovf);
        decodePkg::controlSignals_t c;
        c = decodePkg::controlNop;
        c.regRead1 = ra;
        c.regRead2 = rb;
        c.destinationRegister = rd;
        c.grfWriteSource = decodePkg::grfAlu;
        c.aluCtrl = op;
        c.checkOverflow = ovf;
        return c;
    endfunction

    function automatic decodePkg::controlSignals_t memExpect(
        input decodePkg::regIdx_t ra, rb, input decodePkg::imm16_t imm,
        input decodePkg::memWidth_e width, input logic isLoad, input logic signedRead);
        decodePkg::controlSignals_t c;
        c = decodePkg::controlNop;
        c.regRead1 = ra; // base
        c.aluSrc = 1'b1;
        c.immediate = signExt16(imm);
        c.memWidthCtrl = width;
        if (isLoad)
        begin
            c.destinationRegister = rb;
            c.grfWriteSource = decodePkg::grfMem;
            c.memLoad = 1'b1;
            c.memReadSignExtend = signedRead;
        end
        else
        begin
            c.regRead2 = rb; // store data
            c.memStore = 1'b1;
        end
        return c;
    endfunction

    task automatic checkValue(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
        if (actual !== expected)
        begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic waitValid(input string name);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ctrlValid && cycles < 8);
        if (!ctrlValid)
        begin
            $display("%s: ctrlValid did not rise within 8 cycles", name);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout waiting for ctrlValid");
        end
    endtask

    task automatic applyAndCheck(input string name, input decodePkg::instrWord_t instr,
                                 input decodePkg::controlSignals_t expected);
        instruction = instr;
        instrValid = 1'b1;
        waitValid(name);
        checkValue(name, 128'(expected), 128'(controls));
        #1;
        instrValid = 1'b0;
    endtask

    task automatic aluRegisterOps;
        logic [5:0] fn [10];
        decodePkg::aluOp_e ops [10];
        logic [5:0] shFn [6];
        decodePkg::aluOp_e shOps [6];
        decodePkg::controlSignals_t expected;
        // addu subu add sub and or nor xor slt sltu
        fn = '{6'h21, 6'h23, 6'h20, 6'h22, 6'h24, 6'h25, 6'h27, 6'h26, 6'h2a, 6'h2b};
        ops = '{decodePkg::aluAdd, decodePkg::aluSub, decodePkg::aluAdd, decodePkg::aluSub,
                decodePkg::aluAnd, decodePkg::aluOr, decodePkg::aluNor, decodePkg::aluXor,
                decodePkg::aluSlt, decodePkg::aluSltu};
        for (int i = 0; i < 10; i++)
        begin
            pickOperands();
            expected = aluRegExpect(rsR, rtR, rdR, ops[i], i == 2 || i == 3); // add, sub
            applyAndCheck("aluReg", rType(rsR, rtR, rdR, 5'd0, fn[i]), expected);
        end
        shFn = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
        shOps = '{decodePkg::aluSll, decodePkg::aluSrl, decodePkg::aluSra,
                  decodePkg::aluSll, decodePkg::aluSrl, decodePkg::aluSra};
        for (int i = 0; i < 6; i++)
        begin
            pickOperands();
            if (i < 3)
            begin
                expected = aluRegExpect(rtR, 5'd0, rdR, shOps[i], 1'b0);
                expected.aluSrc = 1'b1;
                expected.immediate = {27'd0, shR};
                applyAndCheck("shiftImm", rType(5'd0, rtR, rdR, shR, shFn[i]), expected);
            end
            else
            begin
                expected = aluRegExpect(rtR, rsR, rdR, shOps[i], 1'b0); // amount in rs
                applyAndCheck("shiftVar", rType(rsR, rtR, rdR, 5'd0, shFn[i]), expected);
            end
        end
    endtask

    task automatic immediateOps;
        logic [5:0] opc [8];
        decodePkg::aluOp_e ops [8];
        logic [1:0] kind [8];
        decodePkg::controlSignals_t expected;
        // addiu addi andi ori xori slti sltiu lui
        opc = '{6'h09, 6'h08, 6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0b, 6'h0f};
        ops = '{decodePkg::aluAdd, decodePkg::aluAdd, decodePkg::aluAnd, decodePkg::aluOr,
                decodePkg::aluXor, decodePkg::aluSlt, decodePkg::aluSltu, decodePkg::aluAdd};
        kind = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd0, 2'd0, 2'd2}; // sign, zero, high
        for (int i = 0; i < 8; i++)
        begin
            pickOperands();
            if (kind[i] == 2'd2)
                rsR = 5'd0; // lui has no source
            expected = decodePkg::controlNop;
            expected.regRead1 = rsR;
            expected.destinationRegister = rtR;
            expected.grfWriteSource = decodePkg::grfAlu;
            expected.aluCtrl = ops[i];
            expected.aluSrc = 1'b1;
            expected.checkOverflow = (i == 1);
            case (kind[i])
                2'd1: expected.immediate = {16'd0, immR};
                2'd2: expected.immediate = {immR, 16'd0};
                default: expected.immediate = signExt16(immR);
            endcase
            applyAndCheck("aluImm", iType(opc[i], rsR, rtR, immR), expected);
        end
    endtask

    task automatic memoryAccess;
        logic [5:0] opc [8];
        decodePkg::memWidth_e widths [8];
        logic signedLoad [8];
        decodePkg::controlSignals_t expected;
        // lw lh lhu lb lbu, then sw sh sb
        opc = '{6'h23, 6'h21, 6'h25, 6'h20, 6'h24, 6'h2b, 6'h29, 6'h28};
        widths = '{decodePkg::memWord, decodePkg::memHalf, decodePkg::memHalf,
                   decodePkg::memByte, decodePkg::memByte, decodePkg::memWord,
                   decodePkg::memHalf, decodePkg::memByte};
        signedLoad = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
        for (int i = 0; i < 8; i++)
        begin
            pickOperands();
            expected = memExpect(rsR, rtR, immR, widths[i], i < 5, signedLoad[i]);
            applyAndCheck("memory", iType(opc[i], rsR, rtR, immR), expected);
        end
    endtask

    task automatic branchesAndJumps;
        decodePkg::cmpOp_e cmps [8];
        logic [5:0] opc;
        logic [4:0] rtField;
        logic [31:0] v;
        decodePkg::instrWord_t instr;
        decodePkg::controlSignals_t expected;
        // beq bne blez bgtz bltz bgez bltzal bgezal
        cmps = '{decodePkg::cmpEq, decodePkg::cmpNe, decodePkg::cmpLez, decodePkg::cmpGtz,
                 decodePkg::cmpLtz, decodePkg::cmpGez, decodePkg::cmpLtz, decodePkg::cmpGez};
        for (int lk = 0; lk < 2; lk++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                pickOperands();
                if (k < 4)
                begin
                    opc = {1'b0, lk[0], 2'b01, k[1:0]}; // likely forms at 0x14
                    rtField = (k < 2) ? rtR : 5'd0;
                end
                else
                begin
                    opc = 6'h01; // REGIMM
                    rtField = {k[1], 2'b00, lk[0], k[0]};
                end
                expected = decodePkg::controlNop;
                expected.regRead1 = rsR;
                expected.regRead2 = (k < 2) ? rtR : 5'd0;
                expected.branch = 1'b1;
                expected.cmpCtrl = cmps[k];
                expected.branchLikely = lk[0];
                expected.immediate = signExt16(immR);
                if (k >= 6)
                begin
                    expected.destinationRegister = 5'd31;
                    expected.grfWriteSource = decodePkg::grfPc;
                end
                applyAndCheck("branch", iType(opc, rsR, rtField, immR), expected);
            end
        end
        for (int i = 0; i < 4; i++) // j jal jr jalr
        begin
            pickOperands();
            takeBits(26, v);
            expected = decodePkg::controlNop;
            expected.absJump = 1'b1;
            if (i < 2)
            begin
                expected.immediate = {6'd0, v[25:0]};
                instr = {5'b00001, i[0], v[25:0]};
            end
            else
            begin
                expected.regRead1 = rsR;
                expected.absJumpFromRegister = 1'b1;
                instr = rType(rsR, 5'd0, (i == 3) ? rdR : 5'd0, 5'd0, {5'b00100, i[0]});
            end
            if (i == 1 || i == 3)
            begin
                expected.destinationRegister = (i == 3) ? rdR : 5'd31;
                expected.grfWriteSource = decodePkg::grfPc;
            end
            applyAndCheck("jump", instr, expected);
        end
    endtask

    task automatic exceptionCases;
        decodePkg::controlSignals_t expected;
        expected = decodePkg::controlNop;
        expected.exception = decodePkg::excSyscall;
        applyAndCheck("syscall", rType(5'd0, 5'd0, 5'd0, 5'd0, 6'h0c), expected);
        expected.exception = decodePkg::excBreak;
        applyAndCheck("break", rType(5'd0, 5'd0, 5'd0, 5'd0, 6'h0d), expected);
        expected.exception = decodePkg::excEret;
        applyAndCheck("eret", 32'h4200_0018, expected);
        expected = decodePkg::controlNop;
        expected.unknownInstruction = 1'b1;
        pickOperands();
        applyAndCheck("mult", rType(rsR, rtR, 5'd0, 5'd0, 6'h18), expected);
        applyAndCheck("lwl", iType(6'h22, rsR, rtR, immR), expected);
        applyAndCheck("unused opcode", iType(6'h3f, rsR, rtR, immR), expected);
    endtask

    task automatic streamAndBubble;
        decodePkg::instrWord_t instrs [12];
        decodePkg::controlSignals_t exps [12];
        logic [31:0] v;
        for (int i = 0; i < 12; i++)
        begin
            pickOperands();
            takeBits(1, v);
            if (v[0])
            begin
                instrs[i] = rType(rsR, rtR, rdR, 5'd0, 6'h21); // addu
                exps[i] = aluRegExpect(rsR, rtR, rdR, decodePkg::aluAdd, 1'b0);
            end
            else
            begin
                instrs[i] = iType(6'h23, rsR, rtR, immR); // lw
                exps[i] = memExpect(rsR, rtR, immR, decodePkg::memWord, 1'b1, 1'b0);
            end
        end
        // one cycle of latency puts each word on controls right after the next edge
        for (int i = 0; i < 12; i++)
        begin
            instruction = instrs[i];
            instrValid = 1'b1;
            @(posedge clk);
            #1;
            checkValue("stream valid", 128'(1'b1), 128'(ctrlValid));
            checkValue("stream controls", 128'(exps[i]), 128'(controls));
            #1;
        end
        instruction = instrs[0];
        instrValid = 1'b1;
        bubble = 1'b1; // also covers the last stream word still held
        @(posedge clk);
        #1;
        checkValue("bubble valid", 128'(1'b1), 128'(ctrlValid));
        checkValue("bubble controls", 128'(decodePkg::controlNop), 128'(controls));
        #1;
        bubble = 1'b0;
        instrValid = 1'b0;
        #1;
        checkValue("after bubble", 128'(exps[0]), 128'(controls)); // held word comes back
        @(posedge clk);
        #1;
        checkValue("gap valid", 128'(1'b0), 128'(ctrlValid));
        checkValue("gap controls", 128'(decodePkg::controlNop), 128'(controls));
    endtask

    initial
    begin
        rstN = 1'b0;
        instrValid = 1'b0;
        instruction = '0;
        bubble = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;
        checkValue("reset valid", 128'(1'b0), 128'(ctrlValid));
        checkValue("reset controls", 128'(decodePkg::controlNop), 128'(controls));
        aluRegisterOps();
        immediateOps();
        memoryAccess();
        branchesAndJumps();
        exceptionCases();
        streamAndBubble();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* test/decodeTop_checker.sv */
module decodeTop_checker (
    input logic clk,
    input logic rstN,
    input logic instrValid,
    input logic bubble,
    input logic ctrlValid,
    input decodePkg::controlSignals_t controls
);
    timeunit 1ns;
    timeprecision 100ps;

    validFollows: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |=> ctrlValid)
        else $error("ctrlValid missing one cycle after instrValid");

    gapFollows: assert property (@(posedge clk) disable iff (!rstN)
        !instrValid |=> !ctrlValid) // empty slot shows up as a gap
        else $error("ctrlValid high one cycle after an empty slot");

    quietInReset: assert property (@(posedge clk) !rstN |-> !ctrlValid)
        else $error("ctrlValid high while reset is asserted");

    bubbleKills: assert property (@(posedge clk) bubble |-> controls == decodePkg::controlNop)
        else $error("controls differ from nop while bubble is high");

endmodule
